// File: src/icache_pkg.sv
// ============================================================
// shared widths, bus structs and state enums of the i-cache
// blocks are 64 bits and hold two instructions; pc bit 2 picks one
// ============================================================
`default_nettype none

package icache_pkg;

    parameter int addr_w   = 32;
    parameter int inst_w   = 32;
    parameter int block_w  = 64;
    parameter int offset_w = 3;

    // read response codes, as on the bus
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    typedef struct packed {
        logic [addr_w-1:0] pc;
    } fetch_req_t;

    typedef struct packed {
        logic [inst_w-1:0] inst;
        logic              err;
    } fetch_rsp_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
    } mem_ar_t;

    typedef struct packed {
        logic [block_w-1:0] data;
        axi_resp_e          resp;
    } mem_r_t;

    // ok low means the block must not be cached
    typedef struct packed {
        logic [block_w-1:0] block;
        logic [addr_w-1:0]  addr;
        logic               ok;
    } refill_t;

    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_ADDR,
        MISS_DATA
    } miss_state_e;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_LOOKUP,
        CTRL_MISS,
        CTRL_RESP
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: src/icache_tag_store.sv
// ============================================================
// tags, valid bits and replacement bits of a 2-way i-cache
// num_sets must be a power of two; hit is valid the cycle after
// lookup_valid and holds until the next lookup
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module icache_tag_store #(
    parameter int num_sets = 256
) (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         lookup_valid,
    input  wire logic [icache_pkg::addr_w-1:0] lookup_addr,
    input  wire logic                         refill_valid,
    input  wire icache_pkg::refill_t          refill,
    output logic                              hit,
    output logic                              hit_way,
    output logic                              victim_way
);

    localparam int idx_w = $clog2(num_sets);
    localparam int tag_w = icache_pkg::addr_w - icache_pkg::offset_w - idx_w;

    logic [tag_w-1:0]    tag_mem [2][num_sets];
    logic [num_sets-1:0] valid_q [2];
    logic [num_sets-1:0] repl_q;

    logic [idx_w-1:0] look_idx_q;
    logic [tag_w-1:0] look_tag_q;
    logic [idx_w-1:0] ref_idx;
    logic [tag_w-1:0] ref_tag;
    logic             hit0;
    logic             hit1;
    logic             fill;

    // capture the lookup address, compare next cycle
    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            look_idx_q <= lookup_addr[icache_pkg::offset_w +: idx_w];
            look_tag_q <= lookup_addr[icache_pkg::addr_w-1 -: tag_w];
        end
    end

    assign hit0    = valid_q[0][look_idx_q] && (tag_mem[0][look_idx_q] == look_tag_q);
    assign hit1    = valid_q[1][look_idx_q] && (tag_mem[1][look_idx_q] == look_tag_q);
    assign hit     = hit0 | hit1;
    assign hit_way = ~hit0;

    // ==========================================================
    // refill side
    assign ref_idx = refill.addr[icache_pkg::offset_w +: idx_w];
    assign ref_tag = refill.addr[icache_pkg::addr_w-1 -: tag_w];
    assign fill    = refill_valid && refill.ok;

    // empty way first, then the set's replacement bit
    always_comb begin
        if (!valid_q[0][ref_idx]) begin
            victim_way = 1'b0;
        end else if (!valid_q[1][ref_idx]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = repl_q[ref_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[victim_way][ref_idx] <= ref_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            repl_q     <= '0;
        end else if (fill) begin
            valid_q[victim_way][ref_idx] <= 1'b1;
            repl_q[ref_idx]              <= ~victim_way;
        end
    end

endmodule

`default_nettype wire

// File: src/icache_data_store.sv
// ============================================================
// block array for both ways, synchronous read
// outputs hold the last blocks read until the next lookup
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module icache_data_store #(
    parameter int num_sets = 256
) (
    input  wire logic                           clk,
    input  wire logic                           lookup_valid,
    input  wire logic [icache_pkg::addr_w-1:0]  lookup_addr,
    input  wire logic                           refill_valid,
    input  wire icache_pkg::refill_t            refill,
    input  wire logic                           victim_way,
    output logic      [icache_pkg::block_w-1:0] way0_block,
    output logic      [icache_pkg::block_w-1:0] way1_block
);

    localparam int idx_w = $clog2(num_sets);

    logic [icache_pkg::block_w-1:0] blk_mem [2][num_sets];

    logic [idx_w-1:0] look_idx;
    logic [idx_w-1:0] ref_idx;

    assign look_idx = lookup_addr[icache_pkg::offset_w +: idx_w];
    assign ref_idx  = refill.addr[icache_pkg::offset_w +: idx_w];

    // read both ways, tag store decides which one is used
    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            way0_block <= blk_mem[0][look_idx];
            way1_block <= blk_mem[1][look_idx];
        end
        if (refill_valid && refill.ok) begin
            blk_mem[victim_way][ref_idx] <= refill.block;
        end
    end

endmodule

`default_nettype wire

// File: src/icache_miss_unit.sv
// ============================================================
// single-beat block read on the ar/r channels
// one miss at a time; refill_valid pulses in the r handshake cycle
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module icache_miss_unit (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          miss_start,
    input  wire logic [icache_pkg::addr_w-1:0] miss_addr,
    output logic                               ar_valid,
    input  wire logic                          ar_ready,
    output icache_pkg::mem_ar_t                ar,
    input  wire logic                          r_valid,
    output logic                               r_ready,
    input  wire icache_pkg::mem_r_t            r,
    output logic                               refill_valid,
    output icache_pkg::refill_t                refill
);

    icache_pkg::miss_state_e state_q;
    icache_pkg::miss_state_e state_d;

    logic [icache_pkg::addr_w-1:0] addr_q;

    // ==========================================================
    // state machine
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            icache_pkg::MISS_IDLE: begin
                if (miss_start) begin
                    state_d = icache_pkg::MISS_ADDR;
                end
            end
            icache_pkg::MISS_ADDR: begin
                if (ar_ready) begin
                    state_d = icache_pkg::MISS_DATA;
                end
            end
            icache_pkg::MISS_DATA: begin
                if (r_valid) begin
                    state_d = icache_pkg::MISS_IDLE;
                end
            end
            default: begin
                state_d = icache_pkg::MISS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= icache_pkg::MISS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // block aligned, held stable until the r beat
    always_ff @(posedge clk) begin
        if (state_q == icache_pkg::MISS_IDLE && miss_start) begin
            addr_q <= {miss_addr[icache_pkg::addr_w-1:icache_pkg::offset_w],
                       {icache_pkg::offset_w{1'b0}}};
        end
    end

    // ==========================================================
    // bus outputs
    assign ar_valid = (state_q == icache_pkg::MISS_ADDR);
    assign ar.addr  = addr_q;
    assign r_ready  = (state_q == icache_pkg::MISS_DATA);

    assign refill_valid = r_valid && r_ready;
    assign refill.block = r.data;
    assign refill.addr  = addr_q;
    // anything but OKAY is passed on as an error and not cached
    assign refill.ok    = (r.resp == icache_pkg::OKAY);

endmodule

`default_nettype wire

// File: src/icache_fetch_ctrl.sv
// ============================================================
// core side sequencing: accept, lookup, miss or response
// one request in flight; the core must take rsp when rsp_valid
// is high, there is no back-pressure
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module icache_fetch_ctrl (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           req_valid,
    output logic                                req_ready,
    input  wire icache_pkg::fetch_req_t         req,
    input  wire logic                           flush,
    output logic                                rsp_valid,
    output icache_pkg::fetch_rsp_t              rsp,
    output logic                                lookup_valid,
    output logic      [icache_pkg::addr_w-1:0]  lookup_addr,
    input  wire logic                           hit,
    input  wire logic                           hit_way,
    input  wire logic [icache_pkg::block_w-1:0] way0_block,
    input  wire logic [icache_pkg::block_w-1:0] way1_block,
    output logic                                miss_start,
    output logic      [icache_pkg::addr_w-1:0]  miss_addr,
    input  wire logic                           refill_valid,
    input  wire icache_pkg::refill_t            refill
);

    icache_pkg::ctrl_state_e state_q;
    icache_pkg::ctrl_state_e state_d;

    logic [icache_pkg::addr_w-1:0]  pc_q;
    logic                           cancel_q;
    logic                           accept;
    logic                           flush_live;
    logic [icache_pkg::block_w-1:0] hit_block;
    logic                           rsp_hit;
    logic                           rsp_fill;

    function automatic logic [icache_pkg::inst_w-1:0] sel_word(
        input logic [icache_pkg::block_w-1:0] block,
        input logic                           upper
    );
        return upper ? block[icache_pkg::block_w-1 -: icache_pkg::inst_w]
                     : block[icache_pkg::inst_w-1:0];
    endfunction

    assign req_ready    = (state_q == icache_pkg::CTRL_IDLE);
    assign accept       = req_valid && req_ready;
    assign lookup_valid = accept;
    assign lookup_addr  = req.pc;

    assign flush_live = flush && (state_q == icache_pkg::CTRL_LOOKUP ||
                                  state_q == icache_pkg::CTRL_MISS);
    assign miss_start = (state_q == icache_pkg::CTRL_LOOKUP) && !hit;
    assign miss_addr  = pc_q;
    assign hit_block  = hit_way ? way1_block : way0_block;

    // a flush in the refill cycle still cancels
    assign rsp_hit  = (state_q == icache_pkg::CTRL_RESP) && !cancel_q;
    assign rsp_fill = (state_q == icache_pkg::CTRL_MISS) && refill_valid
                      && !(cancel_q || flush);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            icache_pkg::CTRL_IDLE:   if (accept) state_d = icache_pkg::CTRL_LOOKUP;
            icache_pkg::CTRL_LOOKUP: state_d = hit ? icache_pkg::CTRL_RESP
                                                   : icache_pkg::CTRL_MISS;
            icache_pkg::CTRL_MISS:   if (refill_valid) state_d = icache_pkg::CTRL_IDLE;
            default:                 state_d = icache_pkg::CTRL_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= icache_pkg::CTRL_IDLE;
            cancel_q  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            state_q   <= state_d;
            rsp_valid <= rsp_hit || rsp_fill;
            if (accept) begin
                cancel_q <= 1'b0;
            end else if (flush_live) begin
                cancel_q <= 1'b1;
            end
        end
    end

    // pc and response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            pc_q <= req.pc;
        end
        if (rsp_hit) begin
            rsp.inst <= sel_word(hit_block, pc_q[2]);
            rsp.err  <= 1'b0;
        end else if (rsp_fill) begin
            rsp.inst <= sel_word(refill.block, pc_q[2]);
            rsp.err  <= !refill.ok;
        end
    end

endmodule

`default_nettype wire

// File: src/icache_top.sv
// ============================================================
// 2-way set-associative instruction cache, 64-bit blocks
// num_sets must be a power of two
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
    parameter int num_sets = 256
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   req_valid,
    output logic                        req_ready,
    input  wire icache_pkg::fetch_req_t req,
    input  wire logic                   flush,
    output logic                        rsp_valid,
    output icache_pkg::fetch_rsp_t      rsp,
    output logic                        ar_valid,
    input  wire logic                   ar_ready,
    output icache_pkg::mem_ar_t         ar,
    input  wire logic                   r_valid,
    output logic                        r_ready,
    input  wire icache_pkg::mem_r_t     r
);

    logic                           lookup_valid;
    logic [icache_pkg::addr_w-1:0]  lookup_addr;
    logic                           hit;
    logic                           hit_way;
    logic                           victim_way;
    logic [icache_pkg::block_w-1:0] way0_block;
    logic [icache_pkg::block_w-1:0] way1_block;
    logic                           miss_start;
    logic [icache_pkg::addr_w-1:0]  miss_addr;
    logic                           refill_valid;
    icache_pkg::refill_t            refill;

    icache_fetch_ctrl u_fetch_ctrl (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_ready(req_ready), .req(req), .flush(flush),
        .rsp_valid(rsp_valid), .rsp(rsp),
        .lookup_valid(lookup_valid), .lookup_addr(lookup_addr),
        .hit(hit), .hit_way(hit_way),
        .way0_block(way0_block), .way1_block(way1_block),
        .miss_start(miss_start), .miss_addr(miss_addr),
        .refill_valid(refill_valid), .refill(refill)
    );

    icache_tag_store #(.num_sets(num_sets)) u_tag_store (
        .clk(clk), .rst(rst),
        .lookup_valid(lookup_valid), .lookup_addr(lookup_addr),
        .refill_valid(refill_valid), .refill(refill),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way)
    );

    icache_data_store #(.num_sets(num_sets)) u_data_store (
        .clk(clk),
        .lookup_valid(lookup_valid), .lookup_addr(lookup_addr),
        .refill_valid(refill_valid), .refill(refill), .victim_way(victim_way),
        .way0_block(way0_block), .way1_block(way1_block)
    );

    icache_miss_unit u_miss_unit (
        .clk(clk), .rst(rst),
        .miss_start(miss_start), .miss_addr(miss_addr),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
        .r_valid(r_valid), .r_ready(r_ready), .r(r),
        .refill_valid(refill_valid), .refill(refill)
    );

endmodule

`default_nettype wire

// File: tb/icache_properties.sv
// ============================================================
// bound into icache_top; checks the ar/r and response handshakes
// failures is read by the testbench at the end of the run
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module icache_properties (
    input wire logic                clk,
    input wire logic                rst,
    input wire logic                ar_valid,
    input wire logic                ar_ready,
    input wire icache_pkg::mem_ar_t ar,
    input wire logic                r_ready,
    input wire logic                rsp_valid,
    input wire logic                req_ready
);

    int failures = 0;

    // ar held with a stable address until accepted
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else begin
            $error("ar_valid dropped or ar changed before ar_ready");
            failures++;
        end

    // data phase opens only right after an accepted address
    r_after_ar: assert property (@(posedge clk) disable iff (rst)
        $rose(r_ready) |-> $past(ar_valid && ar_ready))
        else begin
            $error("r_ready rose without an ar handshake the cycle before");
            failures++;
        end

    rsp_pulse: assert property (@(posedge clk) disable iff (rst) rsp_valid |=> !rsp_valid)
        else begin
            $error("rsp_valid lasted more than one cycle");
            failures++;
        end

    // the response cycle is always an idle cycle
    rsp_idle: assert property (@(posedge clk) disable iff (rst) rsp_valid |-> req_ready)
        else begin
            $error("rsp_valid high while req_ready was low");
            failures++;
        end

    reset_quiet: assert property (@(posedge clk) rst |=> !ar_valid && !rsp_valid)
        else begin
            $error("ar_valid or rsp_valid high right after reset");
            failures++;
        end

endmodule

`default_nettype wire

// File: tb/icache_tb.sv
// ============================================================
// replays tb/icache_cases.txt against icache_top
// memory word at byte address a is a ^ word_salt; addresses at
// or above err_base answer SLVERR
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    localparam logic [31:0] word_salt = 32'h5A5A_0F0F;
    localparam logic [31:0] err_base  = 32'hF000_0000;
    localparam int          max_cases = 64;

    logic                   clk;
    logic                   rst;
    logic                   req_valid;
    logic                   req_ready;
    icache_pkg::fetch_req_t req;
    logic                   flush;
    logic                   rsp_valid;
    icache_pkg::fetch_rsp_t rsp;
    logic                   ar_valid;
    logic                   ar_ready;
    icache_pkg::mem_ar_t    ar;
    logic                   r_valid;
    logic                   r_ready;
    icache_pkg::mem_r_t     r;

    logic [31:0] case_pc [max_cases];
    logic [31:0] case_inst [max_cases];
    logic        case_flush [max_cases];
    int          case_miss [max_cases];
    int          case_err [max_cases];
    int          case_rsp [max_cases];
    int          num_cases = 0;
    logic        loaded = 1'b0;
    int          errors = 0;
    int          ar_count = 0;
    int          rsp_count = 0;
    logic [31:0] rsp_inst;
    logic        rsp_err;

    icache_top dut0 (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_ready(req_ready), .req(req), .flush(flush),
        .rsp_valid(rsp_valid), .rsp(rsp),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
        .r_valid(r_valid), .r_ready(r_ready), .r(r)
    );

    bind icache_top icache_properties u_props (
        .clk(clk), .rst(rst), .ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
        .r_ready(r_ready), .rsp_valid(rsp_valid), .req_ready(req_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================================
    // memory model
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return a ^ word_salt;
    endfunction

    function automatic icache_pkg::mem_r_t read_block(input logic [31:0] addr);
        icache_pkg::mem_r_t beat;
        beat.data = {mem_word(addr + 32'd4), mem_word(addr)};
        beat.resp = (addr >= err_base) ? icache_pkg::SLVERR : icache_pkg::OKAY;
        return beat;
    endfunction

    // random 0..3 cycle delays on ar_ready and r_valid
    initial begin
        int          delay;
        logic [31:0] addr;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r        = '0;
        void'($urandom(32'h3267));
        forever begin
            @(posedge clk);
            if (ar_valid) begin
                addr  = ar.addr;
                delay = $urandom % 4;
                repeat (delay) @(posedge clk);
                ar_ready <= 1'b1;
                @(posedge clk);
                ar_ready <= 1'b0;
                delay = $urandom % 4;
                repeat (delay) @(posedge clk);
                r_valid <= 1'b1;
                r       <= read_block(addr);
                @(posedge clk);
                r_valid <= 1'b0;
            end
        end
    end

    // mid-cycle monitor of both handshakes
    always @(negedge clk) begin
        if (!rst) begin
            if (ar_valid && ar_ready) begin
                ar_count++;
            end
            if (rsp_valid) begin
                rsp_count++;
                rsp_inst = rsp.inst;
                rsp_err  = rsp.err;
            end
        end
    end

    // ========================================================
    // case file
    task automatic load_cases();
        int    fd;
        int    n;
        string line;
        string rest;
        logic  is_flush;
        fd = $fopen("tb/icache_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file tb/icache_cases.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                is_flush = (line.substr(0, 10) == "fetch_flush");
                if (is_flush) begin
                    rest = line.substr(11, line.len() - 1);
                end else if (line.substr(0, 4) == "fetch") begin
                    rest = line.substr(5, line.len() - 1);
                end else begin
                    $display("unknown op in case line: %s", line);
                    errors++;
                    continue;
                end
                if (num_cases >= max_cases) begin
                    $display("too many cases, the rest of the file is ignored");
                    errors++;
                    break;
                end
                n = $sscanf(rest, "%h %h %d %d %d", case_pc[num_cases],
                            case_inst[num_cases], case_miss[num_cases],
                            case_err[num_cases], case_rsp[num_cases]);
                if (n != 5) begin
                    $display("malformed case line: %s", line);
                    errors++;
                end else begin
                    case_flush[num_cases] = is_flush;
                    num_cases++;
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
    endtask

    task automatic run_case(input int k);
        int ar_before;
        int rsp_before;
        int got_ar;
        int got_rsp;
        ar_before  = ar_count;
        rsp_before = rsp_count;
        @(posedge clk);
        req_valid <= 1'b1;
        req.pc    <= case_pc[k];
        do @(posedge clk); while (!req_ready);
        req_valid <= 1'b0;
        flush     <= case_flush[k];
        @(posedge clk);
        flush <= 1'b0;
        // back in idle means the fetch is over, with or without a response
        do @(negedge clk); while (!req_ready);
        @(posedge clk);
        got_ar  = ar_count - ar_before;
        got_rsp = rsp_count - rsp_before;
        assert (got_ar == ((case_miss[k] != 0) ? 1 : 0)) else begin
            $display("MISMATCH case %0d pc %h: ar_handshakes got %h expected %h",
                     k, case_pc[k], got_ar, case_miss[k]);
            errors++;
        end
        if (case_rsp[k] == 0) begin
            assert (got_rsp == 0) else begin
                $display("case %0d pc %h: a response came for a flushed fetch", k, case_pc[k]);
                errors++;
            end
        end else begin
            assert (got_rsp != 0) else begin
                $display("case %0d pc %h: no response came for the fetch", k, case_pc[k]);
                errors++;
            end
            if (got_rsp != 0) begin
                assert (got_rsp == 1) else begin
                    $display("MISMATCH case %0d pc %h: rsp_count got %h expected %h",
                             k, case_pc[k], got_rsp, 1);
                    errors++;
                end
                assert (rsp_inst == case_inst[k]) else begin
                    $display("MISMATCH case %0d pc %h: rsp.inst got %h expected %h",
                             k, case_pc[k], rsp_inst, case_inst[k]);
                    errors++;
                end
                assert (rsp_err == (case_err[k] != 0)) else begin
                    $display("MISMATCH case %0d pc %h: rsp.err got %h expected %h",
                             k, case_pc[k], rsp_err, case_err[k]);
                    errors++;
                end
            end
        end
    endtask

    // ========================================================
    // main sequence
    initial begin
        int total;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        flush     = 1'b0;
        load_cases();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (req_ready && !rsp_valid && !ar_valid && !r_ready) else begin
            $display("handshake outputs not in their idle state after reset");
            errors++;
        end
        for (int k = 0; k < num_cases; k++) begin
            run_case(k);
        end
        total = errors + dut0.u_props.failures;
        $display("cases %0d, check errors %0d, assertion failures %0d",
                 num_cases, errors, dut0.u_props.failures);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // 40 cycles per case plus reset
    initial begin
        wait (loaded);
        repeat (num_cases * 40 + 20) @(posedge clk);
        $display("timeout: the cases did not finish in %0d cycles", num_cases * 40 + 20);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
src/icache_pkg.sv
src/icache_tag_store.sv
src/icache_data_store.sv
src/icache_miss_unit.sv
src/icache_fetch_ctrl.sv
src/icache_top.sv
tb/icache_properties.sv
tb/icache_tb.sv

// File: run.sh
#!/bin/sh
# builds the i-cache testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module icache_tb -o sim_icache

# a failing assertion must not stop the run before the closing report
./obj_dir/sim_icache +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"

// File: tb/icache_cases.txt
# op pc expected_inst expected_miss expected_err expected_rsp
# op is fetch or fetch_flush (flush the cycle after acceptance); pc and inst in hex
# cold miss, then both words of the block hit
fetch       00001000 5a5a1f0f 1 0 1
fetch       00001000 5a5a1f0f 0 0 1
fetch       00001004 5a5a1f0b 0 0 1
# set 2: two tags fill ways 0 and 1, then both hit
fetch       00002010 5a5a2f1f 1 0 1
fetch       00002810 5a5a271f 1 0 1
fetch       00002010 5a5a2f1f 0 0 1
fetch       00002814 5a5a271b 0 0 1
# third tag evicts way 0 (replacement bit 0)
fetch       00003010 5a5a3f1f 1 0 1
fetch       00002810 5a5a271f 0 0 1
fetch       00002010 5a5a2f1f 1 0 1
fetch       00003014 5a5a3f1b 0 0 1
fetch       00002814 5a5a271b 1 0 1
# flushed miss still fills
fetch_flush 00004020 00000000 1 0 0
fetch       00004020 5a5a4f2f 0 0 1
# error region is never cached
fetch       f0000100 aa5a0e0f 1 1 1
fetch       f0000104 aa5a0e0b 1 1 1
fetch       f0000100 aa5a0e0f 1 1 1
# flushed hit gives no response
fetch_flush 00001000 00000000 0 0 0
fetch       00001004 5a5a1f0b 0 0 1
